// File: dv/read_path_assertions.sv
// Credit and tag rules of the read request arbiter
// Bound into every arbiter instance

`timescale 1ns/1ps

module read_path_assertions (
	input logic                            clock,
	input logic                            rstn,
	input mem_pkg::read_request_t          mem_request,
	input logic [cu_pkg::CREDIT_WIDTH-1:0] mem_credit_count,
	input logic [cu_pkg::CREDIT_WIDTH-1:0] buffer_credit_count [cu_pkg::ARRAY_LANES]
);

	import cu_pkg::*;
	import mem_pkg::*;

	// Failure counts per rule
	int   request_failures = 0;
	int   tag_failures     = 0;
	int   credit_failures  = 0;
	logic credits_bounded;

	// Every lane counter within the buffer size
	always_comb begin
		credits_bounded = 1'b1;
		for (int k = 0; k < ARRAY_LANES; k++) begin
			if (buffer_credit_count[k] > CREDIT_WIDTH'(BUFFER_DEPTH)) begin
				credits_bounded = 1'b0;
			end
		end
	end

	// --------------------
	// Rules
	// --------------------

	// Request follows a cycle with a memory credit in hand
	request_needs_credit: assert property (@(posedge clock) disable iff (!rstn)
		mem_request.valid |-> ($past(mem_credit_count) != '0))
		else begin
			$error("memory request issued with no memory credit");
			request_failures++;
		end

	request_tag_valid: assert property (@(posedge clock) disable iff (!rstn)
		mem_request.valid |-> (mem_request.tag != STRUCT_INVALID))
		else begin
			$error("memory request carries an invalid array tag");
			tag_failures++;
		end

	buffer_credit_bound: assert property (@(posedge clock) disable iff (!rstn)
		credits_bounded)
		else begin
			$error("buffer credit count above the buffer depth");
			credit_failures++;
		end

endmodule

bind read_request_arbiter read_path_assertions arbiter_checks (
	.clock               (clock),
	.rstn                (rstn),
	.mem_request         (mem_request),
	.mem_credit_count    (mem_credit_count),
	.buffer_credit_count (buffer_credit_count)
);

// File: dv/read_path_tb.sv
// Testbench for the compute-unit read path
// Memory model, requesters and consumers, with per-lane data checks

`timescale 1ns/1ps

module read_path_tb;

	import cu_pkg::*;
	import mem_pkg::*;

	localparam int WAIT_LIMIT = 1000;
	// One more than the buffer holds, so the last edge read stalls
	localparam int STALL_CMDS = BUFFER_DEPTH + 1;

	logic           clock;
	logic           rstn;
	logic           enabled;
	requester_cmd_t edge_cmd;
	requester_cmd_t graph_cmd;
	logic           mem_credit;
	read_response_t mem_response;
	logic           edge_consumer_credit;
	logic           graph_consumer_credit;
	logic           edge_cmd_credit;
	logic           graph_cmd_credit;
	read_request_t  mem_request;
	lane_data_t     edge_out;
	lane_data_t     graph_out;

	// Environment knobs, written by the main sequence only
	logic mem_credit_on;
	logic edge_consumer_on;
	logic graph_consumer_on;

	// Lane 0 edge, lane 1 graph
	array_struct_type      lane_tags [ARRAY_LANES] = '{INV_EDGE_ARRAY_DEST, READ_GRAPH_DATA};
	string                 lane_names [ARRAY_LANES] = '{"edge", "graph"};
	int                    cmd_credits [ARRAY_LANES];
	logic [DATA_WIDTH-1:0] expected_q [ARRAY_LANES][$];
	logic [ADDR_WIDTH-1:0] lane_addresses [ARRAY_LANES][$];

	// Memory model state
	read_request_t mem_queue [$];
	int            mem_due [$];
	int            cycle;

	int edge_outstanding;
	int checks;
	int errors;
	int errors_at_start;
	int dropped;

	read_path_top uut (
		.clock                 (clock),
		.rstn                  (rstn),
		.enabled               (enabled),
		.edge_cmd              (edge_cmd),
		.graph_cmd             (graph_cmd),
		.mem_credit            (mem_credit),
		.mem_response          (mem_response),
		.edge_consumer_credit  (edge_consumer_credit),
		.graph_consumer_credit (graph_consumer_credit),
		.edge_cmd_credit       (edge_cmd_credit),
		.graph_cmd_credit      (graph_cmd_credit),
		.mem_request           (mem_request),
		.edge_out              (edge_out),
		.graph_out             (graph_out)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// Reference data, address mixed and rotated left by the tag value
	function automatic logic [DATA_WIDTH-1:0] expected_data(input logic [ADDR_WIDTH-1:0] address,
		input array_struct_type tag);
		logic [DATA_WIDTH-1:0] mixed;
		int                    amount;
		mixed  = address ^ 32'hA5A5_0F0F;
		amount = int'(tag);
		return (mixed << amount) | (mixed >> (DATA_WIDTH - amount));
	endfunction

	// --------------------
	// Memory model
	// --------------------

	// Knobs and requests sampled at the falling edge, driven after the rising edge
	initial begin
		logic next_mem_credit;
		logic next_edge_credit;
		logic next_graph_credit;
		next_mem_credit   = 1'b0;
		next_edge_credit  = 1'b0;
		next_graph_credit = 1'b0;
		forever begin
			@(posedge clock);
			#1;
			mem_credit            = next_mem_credit;
			edge_consumer_credit  = next_edge_credit;
			graph_consumer_credit = next_graph_credit;
			mem_response          = '0;
			// In order, head only
			if ((mem_queue.size() > 0) && (mem_due[0] <= cycle)) begin
				mem_response = '{valid: 1'b1, tag: mem_queue[0].tag,
					data: expected_data(mem_queue[0].address, mem_queue[0].tag)};
				void'(mem_queue.pop_front());
				void'(mem_due.pop_front());
			end
			@(negedge clock);
			cycle++;
			next_mem_credit   = mem_credit_on;
			next_edge_credit  = edge_consumer_on;
			next_graph_credit = graph_consumer_on;
			if (!rstn) begin
				mem_queue.delete();
				mem_due.delete();
			end else if (mem_request.valid) begin
				mem_queue.push_back(mem_request);
				mem_due.push_back(cycle + int'($urandom_range(6, 1)));
			end
			// Demux samples the enable together with the response
			if (mem_response.valid && !enabled) begin
				dropped++;
			end
		end
	end

	// --------------------
	// Checker
	// --------------------

	task automatic compare_output(input int lane, input logic [DATA_WIDTH-1:0] actual);
		logic [DATA_WIDTH-1:0] expected;
		checks++;
		assert (expected_q[lane].size() > 0) else begin
			$display("ERROR %0t: %s output 0x%08h with no read expected", $time,
				lane_names[lane], actual);
			errors++;
		end
		if (expected_q[lane].size() > 0) begin
			expected = expected_q[lane].pop_front();
			assert (actual == expected) else begin
				$display("ERROR %0t: %s output 0x%08h, expected 0x%08h", $time,
					lane_names[lane], actual, expected);
				errors++;
			end
		end
	endtask

	// Outputs only move on the rising edge, so the falling edge sees them settled
	always @(negedge clock) begin
		if (!rstn) begin
			edge_outstanding = 0;
		end else begin
			if (edge_cmd_credit) begin
				cmd_credits[0]++;
			end
			if (graph_cmd_credit) begin
				cmd_credits[1]++;
			end
			if (mem_request.valid && (mem_request.tag == INV_EDGE_ARRAY_DEST)) begin
				edge_outstanding++;
			end
			if (edge_out.valid) begin
				edge_outstanding--;
				compare_output(0, edge_out.data);
			end
			if (graph_out.valid) begin
				compare_output(1, graph_out.data);
			end
			assert (edge_outstanding <= BUFFER_DEPTH) else begin
				$display("ERROR %0t: %0d edge reads outstanding, limit %0d", $time,
					edge_outstanding, BUFFER_DEPTH);
				errors++;
			end
		end
	end

	// --------------------
	// Sequence helpers
	// --------------------

	task automatic apply_reset();
		@(posedge clock);
		#1;
		rstn              = 1'b0;
		enabled           = 1'b1;
		edge_cmd          = '0;
		graph_cmd         = '0;
		mem_credit_on     = 1'b0;
		edge_consumer_on  = 1'b0;
		graph_consumer_on = 1'b0;
		repeat (2) @(posedge clock);
		#1;
		rstn = 1'b1;
		// Each requester starts with one command credit
		for (int k = 0; k < ARRAY_LANES; k++) begin
			cmd_credits[k] = 1;
			expected_q[k].delete();
		end
	endtask

	task automatic drive_cmd(input int lane, input requester_cmd_t cmd);
		if (lane == 0) begin
			edge_cmd = cmd;
		end else begin
			graph_cmd = cmd;
		end
	endtask

	// One-cycle command once the requester holds a credit
	task automatic send_cmd(input int lane, input logic [ADDR_WIDTH-1:0] address);
		int waited;
		waited = 0;
		@(posedge clock);
		#1;
		while ((cmd_credits[lane] == 0) && (waited < WAIT_LIMIT)) begin
			@(posedge clock);
			#1;
			waited++;
		end
		if (cmd_credits[lane] == 0) begin
			$display("%s requester timed out waiting for a command credit", lane_names[lane]);
			errors++;
		end else begin
			cmd_credits[lane]--;
			expected_q[lane].push_back(expected_data(address, lane_tags[lane]));
			drive_cmd(lane, '{valid: 1'b1, address: address});
			@(posedge clock);
			#1;
			drive_cmd(lane, '0);
		end
	endtask

	task automatic send_list(input int lane);
		while (lane_addresses[lane].size() > 0) begin
			send_cmd(lane, lane_addresses[lane].pop_front());
		end
	endtask

	// Both requesters run side by side
	task automatic run_traffic();
		fork
			send_list(0);
			send_list(1);
		join
	endtask

	task automatic wait_lane_empty(input int lane);
		int waited;
		waited = 0;
		while ((expected_q[lane].size() != 0) && (waited < WAIT_LIMIT)) begin
			@(posedge clock);
			#1;
			waited++;
		end
		if (expected_q[lane].size() != 0) begin
			$display("%s lane timed out with %0d reads still expected", lane_names[lane],
				expected_q[lane].size());
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		if (errors == errors_at_start) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: FAILED with %0d errors", name, errors - errors_at_start);
		end
		errors_at_start = errors;
	endtask

	// --------------------
	// Main sequence
	// --------------------

	initial begin
		int lane;
		int dropped_start;
		int drop_target;
		int waited;
		int assertion_failures;
		void'($urandom(18));
		rstn                  = 1'b0;
		enabled               = 1'b1;
		edge_cmd              = '0;
		graph_cmd             = '0;
		mem_credit            = 1'b0;
		mem_response          = '0;
		edge_consumer_credit  = 1'b0;
		graph_consumer_credit = 1'b0;
		mem_credit_on         = 1'b0;
		edge_consumer_on      = 1'b0;
		graph_consumer_on     = 1'b0;

		// Quiet after reset with no credits
		apply_reset();
		repeat (20) begin
			@(negedge clock);
			assert (!mem_request.valid && !edge_out.valid && !graph_out.valid) else begin
				$display("ERROR %0t: output valid with no credits given", $time);
				errors++;
			end
			assert (!edge_cmd_credit && !graph_cmd_credit) else begin
				$display("ERROR %0t: command credit pulse with no command sent", $time);
				errors++;
			end
		end
		@(posedge clock);
		#1;
		// Each requester spends its initial credit at once and must get it back
		mem_credit_on     = 1'b1;
		edge_consumer_on  = 1'b1;
		graph_consumer_on = 1'b1;
		lane_addresses[0].push_back($urandom());
		lane_addresses[1].push_back($urandom());
		run_traffic();
		wait_lane_empty(0);
		wait_lane_empty(1);
		assert ((cmd_credits[0] == 1) && (cmd_credits[1] == 1)) else begin
			$display("ERROR %0t: requesters did not get their initial command credit back",
				$time);
			errors++;
		end
		end_test("reset_idle");

		// Single requester runs, the other lane must stay silent
		for (int t = 0; t < ARRAY_LANES; t++) begin
			apply_reset();
			mem_credit_on     = 1'b1;
			edge_consumer_on  = 1'b1;
			graph_consumer_on = 1'b1;
			for (int i = 0; i < 12; i++) begin
				lane_addresses[t].push_back($urandom());
			end
			run_traffic();
			wait_lane_empty(t);
			repeat (10) @(posedge clock);
			end_test((t == 0) ? "edge_only" : "graph_only");
		end

		// Mixed traffic
		apply_reset();
		mem_credit_on     = 1'b1;
		edge_consumer_on  = 1'b1;
		graph_consumer_on = 1'b1;
		for (int i = 0; i < 40; i++) begin
			lane = int'($urandom_range(1, 0));
			lane_addresses[lane].push_back($urandom());
		end
		run_traffic();
		wait_lane_empty(0);
		wait_lane_empty(1);
		end_test("mixed");

		// Edge consumer stalled, graph keeps flowing
		apply_reset();
		mem_credit_on     = 1'b1;
		graph_consumer_on = 1'b1;
		for (int i = 0; i < STALL_CMDS; i++) begin
			lane_addresses[0].push_back($urandom());
		end
		for (int i = 0; i < 10; i++) begin
			lane_addresses[1].push_back($urandom());
		end
		run_traffic();
		wait_lane_empty(1);
		repeat (20) @(posedge clock);
		#1;
		assert (expected_q[0].size() == STALL_CMDS) else begin
			$display("ERROR %0t: edge lane delivered data while stalled", $time);
			errors++;
		end
		assert (edge_outstanding == BUFFER_DEPTH) else begin
			$display("ERROR %0t: %0d edge reads outstanding while stalled, expected %0d",
				$time, edge_outstanding, BUFFER_DEPTH);
			errors++;
		end
		edge_consumer_on = 1'b1;
		wait_lane_empty(0);
		end_test("edge_backpressure");

		// No memory credit, then responses dropped while disabled
		apply_reset();
		edge_consumer_on  = 1'b1;
		graph_consumer_on = 1'b1;
		send_cmd(0, $urandom());
		send_cmd(1, $urandom());
		repeat (20) begin
			@(negedge clock);
			assert (!mem_request.valid) else begin
				$display("ERROR %0t: memory request with no memory credit", $time);
				errors++;
			end
		end
		@(posedge clock);
		#1;
		drop_target = expected_q[0].size() + expected_q[1].size();
		expected_q[0].delete();
		expected_q[1].delete();
		dropped_start = dropped;
		enabled       = 1'b0;
		mem_credit_on = 1'b1;
		waited        = 0;
		while (((dropped - dropped_start) < drop_target) && (waited < WAIT_LIMIT)) begin
			@(posedge clock);
			#1;
			waited++;
		end
		if ((dropped - dropped_start) < drop_target) begin
			$display("timed out waiting for %0d responses while disabled", drop_target);
			errors++;
		end
		// Flush the demux stages with the enable still low
		repeat (8) @(posedge clock);
		#1;
		enabled = 1'b1;
		$display("dropped %0d of %0d responses", dropped - dropped_start, drop_target);
		end_test("no_credit_disabled");

		assertion_failures = uut.arbiter.arbiter_checks.request_failures +
			uut.arbiter.arbiter_checks.tag_failures +
			uut.arbiter.arbiter_checks.credit_failures;
		$display("checks %0d, errors %0d, assertion failures %0d, dropped %0d", checks, errors,
			assertion_failures, dropped);
		if ((errors == 0) && (assertion_failures == 0)) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: project.f
src/cu_pkg.sv
src/mem_pkg.sv
src/read_request_arbiter.sv
src/response_demux_bus.sv
src/response_buffer.sv
src/read_path_top.sv
dv/read_path_assertions.sv
dv/read_path_tb.sv

// File: src/cu_pkg.sv
// Compute-unit definitions shared by the read path
// Array tags, lane count, buffer sizing and credit widths

package cu_pkg;

	// --------------------
	// Array kinds
	// --------------------

	// Tag carried with every read, lane order follows the demux outputs
	typedef enum logic [1:0] {
		STRUCT_INVALID      = 2'd0,
		INV_EDGE_ARRAY_DEST = 2'd1,
		READ_GRAPH_DATA     = 2'd2
	} array_struct_type;

	// --------------------
	// Sizing
	// --------------------

	localparam int ARRAY_LANES        = 2;
	localparam int LANE_INDEX_WIDTH   = $clog2(ARRAY_LANES);
	// Entries per response buffer, also the arbiter's starting credit
	localparam int BUFFER_DEPTH       = 4;
	localparam int BUFFER_PTR_WIDTH   = $clog2(BUFFER_DEPTH);
	localparam int BUFFER_COUNT_WIDTH = $clog2(BUFFER_DEPTH + 1);
	localparam int CREDIT_WIDTH       = 4;

	// Lane index to array tag
	function automatic array_struct_type lane_tag(input int lane);
		case (lane)
			0:       return INV_EDGE_ARRAY_DEST;
			1:       return READ_GRAPH_DATA;
			default: return STRUCT_INVALID;
		endcase
	endfunction

endpackage

// File: src/mem_pkg.sv
// Memory interface definitions for the read path
// Request, response and lane payload structs with their widths

package mem_pkg;

	// --------------------
	// Widths
	// --------------------

	localparam int ADDR_WIDTH      = 32;
	localparam int DATA_WIDTH      = 32;
	// Upper bound of request slots memory may grant
	localparam int MEM_CREDITS_MAX = 8;

	// --------------------
	// Structs
	// --------------------

	// Tagged read request towards memory
	typedef struct packed {
		logic                     valid;
		cu_pkg::array_struct_type tag;
		logic [ADDR_WIDTH-1:0]    address;
	} read_request_t;

	// In-order read response from memory
	typedef struct packed {
		logic                     valid;
		cu_pkg::array_struct_type tag;
		logic [DATA_WIDTH-1:0]    data;
	} read_response_t;

	// Payload on one lane after the tag is stripped
	typedef struct packed {
		logic                  valid;
		logic [DATA_WIDTH-1:0] data;
	} lane_data_t;

	// Command from one requester
	typedef struct packed {
		logic                  valid;
		logic [ADDR_WIDTH-1:0] address;
	} requester_cmd_t;

endpackage

// File: src/read_path_top.sv
// Read path of the compute unit
// Arbiter towards memory, response demux and one buffer per array lane

`timescale 1ns/1ps

module read_path_top (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    enabled,
	input  mem_pkg::requester_cmd_t edge_cmd,
	input  mem_pkg::requester_cmd_t graph_cmd,
	input  logic                    mem_credit,
	input  mem_pkg::read_response_t mem_response,
	input  logic                    edge_consumer_credit,
	input  logic                    graph_consumer_credit,
	output logic                    edge_cmd_credit,
	output logic                    graph_cmd_credit,
	output mem_pkg::read_request_t  mem_request,
	output mem_pkg::lane_data_t     edge_out,
	output mem_pkg::lane_data_t     graph_out
);

	import cu_pkg::*;
	import mem_pkg::*;

	// Demux lanes into the buffers
	lane_data_t             lane_out [ARRAY_LANES];
	// Pops returned to the arbiter
	logic [ARRAY_LANES-1:0] buffer_credit;

	// --------------------
	// Request side
	// --------------------

	read_request_arbiter arbiter (
		.clock            (clock),
		.rstn             (rstn),
		.edge_cmd         (edge_cmd),
		.graph_cmd        (graph_cmd),
		.mem_credit       (mem_credit),
		.buffer_credit    (buffer_credit),
		.mem_request      (mem_request),
		.edge_cmd_credit  (edge_cmd_credit),
		.graph_cmd_credit (graph_cmd_credit)
	);

	// --------------------
	// Response side
	// --------------------

	response_demux_bus demux (
		.clock    (clock),
		.rstn     (rstn),
		.enabled  (enabled),
		.response (mem_response),
		.out      (lane_out)
	);

	// Lane 0, destination vertex indices
	response_buffer edge_buffer (
		.clock           (clock),
		.rstn            (rstn),
		.in              (lane_out[0]),
		.consumer_credit (edge_consumer_credit),
		.out             (edge_out),
		.buffer_credit   (buffer_credit[0])
	);

	// Lane 1, vertex data
	response_buffer graph_buffer (
		.clock           (clock),
		.rstn            (rstn),
		.in              (lane_out[1]),
		.consumer_credit (graph_consumer_credit),
		.out             (graph_out),
		.buffer_credit   (buffer_credit[1])
	);

endmodule

// File: src/read_request_arbiter.sv
// Read request arbiter
// Merges edge and graph commands round robin, spending memory and buffer credits

`timescale 1ns/1ps

module read_request_arbiter (
	input  logic                           clock,
	input  logic                           rstn,
	input  mem_pkg::requester_cmd_t        edge_cmd,
	input  mem_pkg::requester_cmd_t        graph_cmd,
	input  logic                           mem_credit,
	input  logic [cu_pkg::ARRAY_LANES-1:0] buffer_credit,
	output mem_pkg::read_request_t         mem_request,
	output logic                           edge_cmd_credit,
	output logic                           graph_cmd_credit
);

	import cu_pkg::*;
	import mem_pkg::*;

	requester_cmd_t              cmd_in              [ARRAY_LANES];
	requester_cmd_t              pending             [ARRAY_LANES];
	logic [CREDIT_WIDTH-1:0]     mem_credit_count;
	logic [CREDIT_WIDTH-1:0]     buffer_credit_count [ARRAY_LANES];
	logic [ARRAY_LANES-1:0]      eligible;
	logic [ARRAY_LANES-1:0]      grant;
	logic [ARRAY_LANES-1:0]      cmd_credit;
	// Lane that wins when both are eligible
	logic [LANE_INDEX_WIDTH-1:0] rr_ptr;

	// Lane 0 is the edge reader, lane 1 the graph reader
	assign cmd_in[0] = edge_cmd;
	assign cmd_in[1] = graph_cmd;

	// --------------------
	// Pending slots
	// --------------------

	// One command held per requester until it is granted
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			for (int k = 0; k < ARRAY_LANES; k++) begin
				pending[k] <= '0;
			end
		end else begin
			for (int k = 0; k < ARRAY_LANES; k++) begin
				if (cmd_in[k].valid) begin
					pending[k] <= cmd_in[k];
				end else if (grant[k]) begin
					pending[k].valid <= 1'b0;
				end
			end
		end
	end

	// --------------------
	// Eligibility and grant
	// --------------------

	always_comb begin
		for (int k = 0; k < ARRAY_LANES; k++) begin
			eligible[k] = pending[k].valid && (mem_credit_count != '0) &&
				(buffer_credit_count[k] != '0);
		end
	end

	// Search starts at the round-robin pointer, first eligible lane wins
	always_comb begin
		int lane;
		grant = '0;
		for (int k = 0; k < ARRAY_LANES; k++) begin
			lane = (int'(rr_ptr) + k) % ARRAY_LANES;
			if (eligible[lane] && (grant == '0)) begin
				grant[lane] = 1'b1;
			end
		end
	end

	// --------------------
	// Credit counters
	// --------------------

	// Memory credits saturate at the slot count memory can grant
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			mem_credit_count <= '0;
		end else begin
			case ({mem_credit && (mem_credit_count < CREDIT_WIDTH'(MEM_CREDITS_MAX)), |grant})
				2'b10:   mem_credit_count <= mem_credit_count + 1'b1;
				2'b01:   mem_credit_count <= mem_credit_count - 1'b1;
				default: mem_credit_count <= mem_credit_count;
			endcase
		end
	end

	// Each lane starts with a full buffer of credits
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			for (int k = 0; k < ARRAY_LANES; k++) begin
				buffer_credit_count[k] <= CREDIT_WIDTH'(BUFFER_DEPTH);
			end
		end else begin
			for (int k = 0; k < ARRAY_LANES; k++) begin
				case ({buffer_credit[k], grant[k]})
					2'b10:   buffer_credit_count[k] <= buffer_credit_count[k] + 1'b1;
					2'b01:   buffer_credit_count[k] <= buffer_credit_count[k] - 1'b1;
					default: buffer_credit_count[k] <= buffer_credit_count[k];
				endcase
			end
		end
	end

	// --------------------
	// Request issue
	// --------------------

	// Granted command goes out tagged, its requester gets the credit back
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			mem_request <= '{valid: 1'b0, tag: STRUCT_INVALID, address: '0};
			cmd_credit  <= '0;
			rr_ptr      <= '0;
		end else begin
			mem_request.valid <= |grant;
			cmd_credit        <= grant;
			for (int k = 0; k < ARRAY_LANES; k++) begin
				if (grant[k]) begin
					mem_request.tag     <= lane_tag(k);
					mem_request.address <= pending[k].address;
					// Other lane gets priority next time
					rr_ptr              <= LANE_INDEX_WIDTH'((k + 1) % ARRAY_LANES);
				end
			end
		end
	end

	assign edge_cmd_credit  = cmd_credit[0];
	assign graph_cmd_credit = cmd_credit[1];

endmodule

// File: src/response_buffer.sv
// Per-lane response buffer
// Small FIFO that sends against consumer credits and hands credits back upstream

`timescale 1ns/1ps

module response_buffer (
	input  logic                clock,
	input  logic                rstn,
	input  mem_pkg::lane_data_t in,
	input  logic                consumer_credit,
	output mem_pkg::lane_data_t out,
	output logic                buffer_credit
);

	import cu_pkg::*;
	import mem_pkg::*;

	logic [DATA_WIDTH-1:0]         entries [BUFFER_DEPTH];
	logic [BUFFER_PTR_WIDTH-1:0]   wr_ptr;
	logic [BUFFER_PTR_WIDTH-1:0]   rd_ptr;
	logic [BUFFER_COUNT_WIDTH-1:0] fill_count;
	logic [CREDIT_WIDTH-1:0]       consumer_credit_count;
	logic                          push;
	logic                          pop;

	// Upstream credits keep a full buffer from being written
	assign push = in.valid;
	// Head goes out as soon as the consumer holds a credit
	assign pop  = (fill_count != '0) && (consumer_credit_count != '0);

	// --------------------
	// Storage
	// --------------------

	always_ff @(posedge clock) begin
		if (push) begin
			entries[wr_ptr] <= in.data;
		end
	end

	// Depth is a power of two so pointers wrap on their own
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			fill_count <= '0;
		end else begin
			case ({push, pop})
				2'b10:   fill_count <= fill_count + 1'b1;
				2'b01:   fill_count <= fill_count - 1'b1;
				default: fill_count <= fill_count;
			endcase
		end
	end

	// --------------------
	// Consumer credits
	// --------------------

	// Counter holds at its top value
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			consumer_credit_count <= '0;
		end else begin
			case ({consumer_credit, pop})
				2'b10: begin
					if (consumer_credit_count != '1) begin
						consumer_credit_count <= consumer_credit_count + 1'b1;
					end
				end
				2'b01:   consumer_credit_count <= consumer_credit_count - 1'b1;
				default: consumer_credit_count <= consumer_credit_count;
			endcase
		end
	end

	// Send and upstream credit in the same cycle
	assign out           = '{valid: pop, data: entries[rd_ptr]};
	assign buffer_credit = pop;

endmodule

// File: src/response_demux_bus.sv
// Response demultiplexer
// Steers tagged memory responses onto per-array lanes in four register stages

`timescale 1ns/1ps

module response_demux_bus (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    enabled,
	input  mem_pkg::read_response_t response,
	output mem_pkg::lane_data_t     out [cu_pkg::ARRAY_LANES]
);

	import cu_pkg::*;
	import mem_pkg::*;

	logic           enabled_q;
	read_response_t response_q;
	read_response_t response_latched;
	lane_data_t     lane_decoded [ARRAY_LANES];
	lane_data_t     lane_s2      [ARRAY_LANES];

	// --------------------
	// Input and enable
	// --------------------

	// Stage 1, response and enable sampled together
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled_q  <= 1'b0;
			response_q <= '{valid: 1'b0, tag: STRUCT_INVALID, data: '0};
		end else begin
			enabled_q  <= enabled;
			response_q <= response;
		end
	end

	// Stage 2, disabled responses turn into an invalid tag
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			response_latched <= '{valid: 1'b0, tag: STRUCT_INVALID, data: '0};
		end else if (enabled_q) begin
			response_latched <= response_q;
		end else begin
			response_latched <= '{valid: 1'b0, tag: STRUCT_INVALID, data: '0};
		end
	end

	// --------------------
	// Tag decode
	// --------------------

	// Only the matching lane carries data, the rest stay zero
	always_comb begin
		for (int k = 0; k < ARRAY_LANES; k++) begin
			lane_decoded[k] = '0;
			if (response_latched.valid && (response_latched.tag == lane_tag(k))) begin
				lane_decoded[k].valid = 1'b1;
				lane_decoded[k].data  = response_latched.data;
			end
		end
	end

	// --------------------
	// Output stages
	// --------------------

	// Stages 3 and 4
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			lane_s2 <= '{default: '0};
			out     <= '{default: '0};
		end else begin
			lane_s2 <= lane_decoded;
			out     <= lane_s2;
		end
	end

endmodule
